// File: usb_rx_pkg.sv
package usb_rx_pkg;

    // Encoded as {dp, dm}.
    typedef enum logic [1:0] {
        LINE_SE0 = 2'b00,
        LINE_K   = 2'b01,
        LINE_J   = 2'b10,
        LINE_SE1 = 2'b11
    } line_state_t;

    typedef enum logic [1:0] {
        TAG_PID   = 2'd0,
        TAG_DATA  = 2'd1,
        TAG_EOP   = 2'd2,
        TAG_ABORT = 2'd3
    } rx_tag_t;

    typedef struct packed {
        logic [7:0] data;
        rx_tag_t    tag;
    } rx_entry_t;

    // KJKJKJKK after NRZI decoding, LSB first.
    localparam logic [7:0] SYNC_BYTE = 8'h80;

    localparam int DEFAULT_FIFO_DEPTH = 32;
    localparam int DEFAULT_IDLE_BITS  = 16;

    localparam logic [1:0] REG_CTRL      = 2'd0;
    localparam logic [1:0] REG_PKT_COUNT = 2'd1;
    localparam logic [1:0] REG_ERR_COUNT = 2'd2;
    localparam logic [1:0] REG_LAST_PID  = 2'd3;

endpackage

// File: usb_line_sampler.sv
`timescale 1ns/1ps

module usb_line_sampler (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    dp_in,
    input  logic                    dm_in,
    output usb_rx_pkg::line_state_t line_state,
    output logic                    bit_strobe
);
    import usb_rx_pkg::*;

    logic [1:0]  sync_meta;
    logic [1:0]  sync_line;
    line_state_t prev_state;
    logic [1:0]  phase;
    logic        changed;

    assign line_state = line_state_t'(sync_line);
    assign changed    = (line_state != prev_state);

    // Phase 1 after a transition is the bit centre at four clocks per bit.
    assign bit_strobe = (phase == 2'd1) && !changed;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            sync_meta  <= LINE_J;
            sync_line  <= LINE_J;
            prev_state <= LINE_J;
            phase      <= 2'd0;
        end else begin
            sync_meta  <= {dp_in, dm_in};
            sync_line  <= sync_meta;
            prev_state <= line_state;
            if (changed) begin
                phase <= 2'd0;
            end else begin
                phase <= phase + 2'd1;
            end
        end
    end

endmodule

// File: usb_nrzi_decoder.sv
`timescale 1ns/1ps

module usb_nrzi_decoder (
    input  logic                    clk,
    input  logic                    nreset,
    input  usb_rx_pkg::line_state_t line_state,
    input  logic                    bit_strobe,
    output logic                    bit_valid,
    output logic                    bit_value,
    output usb_rx_pkg::line_state_t bit_state,
    output logic                    stuff_error
);
    import usb_rx_pkg::*;

    line_state_t prev_jk;
    logic [2:0]  ones_count;
    logic        is_jk;
    logic        same_state;

    assign is_jk      = (line_state == LINE_J) || (line_state == LINE_K);
    assign same_state = (line_state == prev_jk);

    always_ff @(posedge clk) begin
        if (!nreset) begin
            prev_jk     <= LINE_J;
            ones_count  <= 3'd0;
            bit_valid   <= 1'b0;
            bit_value   <= 1'b0;
            bit_state   <= LINE_J;
            stuff_error <= 1'b0;
        end else begin
            bit_valid   <= 1'b0;
            stuff_error <= 1'b0;
            if (bit_strobe) begin
                bit_state <= line_state;
                if (!is_jk) begin
                    // SE0 and SE1 pass through as zeros.
                    bit_valid  <= 1'b1;
                    bit_value  <= 1'b0;
                    ones_count <= 3'd0;
                    if (line_state == LINE_SE0) begin
                        prev_jk <= LINE_J;
                    end
                end else if (same_state) begin
                    bit_valid <= 1'b1;
                    bit_value <= 1'b1;
                    // Saturates at seven, so a long idle keeps the next zero.
                    if (ones_count == 3'd6) begin
                        stuff_error <= 1'b1;
                        ones_count  <= 3'd7;
                    end else if (ones_count != 3'd7) begin
                        ones_count <= ones_count + 3'd1;
                    end
                end else begin
                    prev_jk    <= line_state;
                    ones_count <= 3'd0;
                    // A zero after six ones is a stuffed bit.
                    if (ones_count != 3'd6) begin
                        bit_valid <= 1'b1;
                        bit_value <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: usb_packet_receiver.sv
`timescale 1ns/1ps

module usb_packet_receiver #(
    parameter int IDLE_BITS = usb_rx_pkg::DEFAULT_IDLE_BITS
) (
    input  logic                    clk,
    input  logic                    nreset,
    input  logic                    rx_enable,
    input  logic                    bit_valid,
    input  logic                    bit_value,
    input  usb_rx_pkg::line_state_t bit_state,
    input  logic                    stuff_error,
    input  logic                    almost_full,
    output logic                    wr_en,
    output usb_rx_pkg::rx_entry_t   wr_entry,
    output logic                    pkt_done,
    output logic                    pkt_error,
    output logic                    pid_seen,
    output logic [7:0]              pid_value
);
    import usb_rx_pkg::*;

    typedef enum logic [2:0] {
        ST_WAIT_IDLE,
        ST_IDLE,
        ST_SYNC,
        ST_PID,
        ST_DATA,
        ST_DROP
    } rx_state_t;

    localparam int IDLE_W = $clog2(IDLE_BITS + 1);

    rx_state_t         state;
    logic [IDLE_W-1:0] idle_count;
    logic [7:0]        shift;
    logic [2:0]        bit_count;
    logic              se0_seen;
    logic [7:0]        next_byte;
    logic              line_j;
    logic              line_se0;
    logic              line_err;
    logic              data_bit;
    logic              byte_done;

    // ########################################################################
    // Bit classification
    // ########################################################################

    assign next_byte = {bit_value, shift[7:1]};
    assign line_j    = bit_valid && (bit_state == LINE_J);
    assign line_se0  = bit_valid && (bit_state == LINE_SE0);
    // SE1 and a stuffing fault both count as a broken line.
    assign line_err  = bit_valid && ((bit_state == LINE_SE1) || stuff_error);
    assign data_bit  = bit_valid && !line_se0 && !line_err;
    assign byte_done = data_bit && (bit_count == 3'd7);

    // ########################################################################
    // Packet FSM
    // ########################################################################

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state      <= ST_WAIT_IDLE;
            idle_count <= '0;
            bit_count  <= 3'd0;
            se0_seen   <= 1'b0;
            wr_en      <= 1'b0;
            pkt_done   <= 1'b0;
            pkt_error  <= 1'b0;
            pid_seen   <= 1'b0;
        end else begin
            wr_en     <= 1'b0;
            pkt_done  <= 1'b0;
            pkt_error <= 1'b0;
            pid_seen  <= 1'b0;

            if (data_bit) begin
                shift     <= next_byte;
                bit_count <= bit_count + 3'd1;
            end

            case (state)
                ST_WAIT_IDLE: begin
                    if (!rx_enable || (bit_valid && !line_j)) begin
                        idle_count <= '0;
                    end else if (line_j) begin
                        if (idle_count == IDLE_W'(IDLE_BITS - 1)) begin
                            idle_count <= '0;
                            state      <= ST_IDLE;
                        end else begin
                            idle_count <= idle_count + 1'b1;
                        end
                    end
                end
                ST_IDLE: begin
                    // First K of SYNC decodes as a zero.
                    if (!rx_enable) begin
                        state <= ST_WAIT_IDLE;
                    end else if (data_bit && !bit_value) begin
                        state     <= ST_SYNC;
                        bit_count <= 3'd1;
                    end
                end
                ST_SYNC: begin
                    if (!rx_enable) begin
                        state <= ST_WAIT_IDLE;
                    end else if (line_se0 || line_err) begin
                        state    <= ST_DROP;
                        se0_seen <= 1'b1;
                    end else if (byte_done) begin
                        if (next_byte == SYNC_BYTE) begin
                            state <= ST_PID;
                        end else begin
                            state    <= ST_DROP;
                            se0_seen <= 1'b1;
                        end
                    end
                end
                ST_PID: begin
                    if (line_se0 || line_err) begin
                        state    <= ST_DROP;
                        se0_seen <= line_se0;
                    end else if (byte_done) begin
                        if ((next_byte[7:4] == ~next_byte[3:0]) && !almost_full) begin
                            wr_en     <= 1'b1;
                            wr_entry  <= '{data: next_byte, tag: TAG_PID};
                            pid_seen  <= 1'b1;
                            pid_value <= next_byte;
                            state     <= ST_DATA;
                        end else begin
                            pkt_error <= 1'b1;
                            state     <= ST_DROP;
                            se0_seen  <= 1'b0;
                        end
                    end
                end
                ST_DATA: begin
                    if (line_se0 && (bit_count == 3'd0)) begin
                        wr_en    <= 1'b1;
                        wr_entry <= '{data: 8'h00, tag: TAG_EOP};
                        pkt_done <= 1'b1;
                        state    <= ST_DROP;
                        se0_seen <= 1'b1;
                    end else if (line_se0 || line_err || (byte_done && almost_full)) begin
                        // Last free slot takes the abort marker.
                        wr_en     <= 1'b1;
                        wr_entry  <= '{data: 8'h00, tag: TAG_ABORT};
                        pkt_error <= 1'b1;
                        state     <= ST_DROP;
                        se0_seen  <= line_se0;
                    end else if (byte_done) begin
                        wr_en    <= 1'b1;
                        wr_entry <= '{data: next_byte, tag: TAG_DATA};
                    end
                end
                ST_DROP: begin
                    // Rest of the packet is ignored up to its EOP.
                    if (!rx_enable) begin
                        state <= ST_WAIT_IDLE;
                    end else if (line_se0) begin
                        se0_seen <= 1'b1;
                    end else if (line_j && se0_seen) begin
                        se0_seen <= 1'b0;
                        state    <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_WAIT_IDLE;
                end
            endcase
        end
    end

endmodule

// File: usb_rx_fifo.sv
`timescale 1ns/1ps

module usb_rx_fifo #(
    parameter int DEPTH = usb_rx_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  nreset,
    input  logic                  wr_en,
    input  usb_rx_pkg::rx_entry_t wr_entry,
    output logic                  almost_full,
    output logic                  out_valid,
    output usb_rx_pkg::rx_entry_t out_entry,
    input  logic                  out_ready
);
    import usb_rx_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    rx_entry_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    assign out_valid   = (count != '0);
    assign out_entry   = mem[rd_ptr];
    // At most one slot left.
    assign almost_full = (count >= CNT_W'(DEPTH - 1));
    assign do_write    = wr_en && (count != CNT_W'(DEPTH));
    assign do_read     = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_write) - CNT_W'(do_read);
        end
    end

endmodule

// File: usb_rx_regs.sv
`timescale 1ns/1ps

module usb_rx_regs (
    input  logic       clk,
    input  logic       nreset,
    input  logic [1:0] reg_addr,
    input  logic [7:0] reg_wdata,
    input  logic       reg_write,
    output logic [7:0] reg_rdata,
    output logic       rx_enable,
    input  logic       pkt_done,
    input  logic       pkt_error,
    input  logic       pid_seen,
    input  logic [7:0] pid_value
);
    import usb_rx_pkg::*;

    logic [7:0] pkt_count;
    logic [7:0] err_count;
    logic [7:0] last_pid;

    always_comb begin
        case (reg_addr)
            REG_CTRL:      reg_rdata = {7'd0, rx_enable};
            REG_PKT_COUNT: reg_rdata = pkt_count;
            REG_ERR_COUNT: reg_rdata = err_count;
            default:       reg_rdata = last_pid;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            rx_enable <= 1'b1;
            pkt_count <= 8'd0;
            err_count <= 8'd0;
            last_pid  <= 8'd0;
        end else begin
            if (reg_write && (reg_addr == REG_CTRL)) begin
                rx_enable <= reg_wdata[0];
            end

            // Counters saturate; a write of any value clears them.
            if (reg_write && (reg_addr == REG_PKT_COUNT)) begin
                pkt_count <= 8'd0;
            end else if (pkt_done && (pkt_count != 8'hff)) begin
                pkt_count <= pkt_count + 8'd1;
            end

            if (reg_write && (reg_addr == REG_ERR_COUNT)) begin
                err_count <= 8'd0;
            end else if (pkt_error && (err_count != 8'hff)) begin
                err_count <= err_count + 8'd1;
            end

            if (pid_seen) begin
                last_pid <= pid_value;
            end
        end
    end

endmodule

// File: usb_rx_top.sv
`timescale 1ns/1ps

module usb_rx_top #(
    parameter int FIFO_DEPTH = usb_rx_pkg::DEFAULT_FIFO_DEPTH,
    parameter int IDLE_BITS  = usb_rx_pkg::DEFAULT_IDLE_BITS
) (
    input  logic                  clk,
    input  logic                  nreset,
    input  logic                  dp_in,
    input  logic                  dm_in,
    output logic                  out_valid,
    output usb_rx_pkg::rx_entry_t out_entry,
    input  logic                  out_ready,
    input  logic [1:0]            reg_addr,
    input  logic [7:0]            reg_wdata,
    input  logic                  reg_write,
    output logic [7:0]            reg_rdata
);
    import usb_rx_pkg::*;

    line_state_t line_state;
    logic        bit_strobe;
    logic        bit_valid;
    logic        bit_value;
    line_state_t bit_state;
    logic        stuff_error;
    logic        almost_full;
    logic        wr_en;
    rx_entry_t   wr_entry;
    logic        rx_enable;
    logic        pkt_done;
    logic        pkt_error;
    logic        pid_seen;
    logic [7:0]  pid_value;

    // ########################################################################
    // Line side
    // ########################################################################

    usb_line_sampler i_usb_line_sampler (
        .clk        (clk),
        .nreset     (nreset),
        .dp_in      (dp_in),
        .dm_in      (dm_in),
        .line_state (line_state),
        .bit_strobe (bit_strobe)
    );

    usb_nrzi_decoder i_usb_nrzi_decoder (
        .clk         (clk),
        .nreset      (nreset),
        .line_state  (line_state),
        .bit_strobe  (bit_strobe),
        .bit_valid   (bit_valid),
        .bit_value   (bit_value),
        .bit_state   (bit_state),
        .stuff_error (stuff_error)
    );

    usb_packet_receiver #(
        .IDLE_BITS (IDLE_BITS)
    ) i_usb_packet_receiver (
        .clk         (clk),
        .nreset      (nreset),
        .rx_enable   (rx_enable),
        .bit_valid   (bit_valid),
        .bit_value   (bit_value),
        .bit_state   (bit_state),
        .stuff_error (stuff_error),
        .almost_full (almost_full),
        .wr_en       (wr_en),
        .wr_entry    (wr_entry),
        .pkt_done    (pkt_done),
        .pkt_error   (pkt_error),
        .pid_seen    (pid_seen),
        .pid_value   (pid_value)
    );

    // ########################################################################
    // Consumer and register side
    // ########################################################################

    usb_rx_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_usb_rx_fifo (
        .clk         (clk),
        .nreset      (nreset),
        .wr_en       (wr_en),
        .wr_entry    (wr_entry),
        .almost_full (almost_full),
        .out_valid   (out_valid),
        .out_entry   (out_entry),
        .out_ready   (out_ready)
    );

    usb_rx_regs i_usb_rx_regs (
        .clk       (clk),
        .nreset    (nreset),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_write (reg_write),
        .reg_rdata (reg_rdata),
        .rx_enable (rx_enable),
        .pkt_done  (pkt_done),
        .pkt_error (pkt_error),
        .pid_seen  (pid_seen),
        .pid_value (pid_value)
    );

endmodule

// File: usb_rx_chk.sv
`timescale 1ns/1ps

module usb_rx_chk #(
    parameter int DEPTH = 8
) (
    input logic                  clk,
    input logic                  nreset,
    input logic                  out_valid,
    input usb_rx_pkg::rx_entry_t out_entry,
    input logic                  out_ready,
    input logic                  wr_en,
    input logic [31:0]           fifo_count
);

    // Stalled entry must not change.
    a_stall_stable: assert property (@(posedge clk) disable iff (!nreset)
        out_valid && !out_ready |=> $stable(out_entry))
        else $error("out_entry changed while stalled");

    a_no_write_full: assert property (@(posedge clk) disable iff (!nreset)
        !(wr_en && (fifo_count == DEPTH)))
        else $error("wr_en high while the FIFO is full");

    a_reset_idle: assert property (@(posedge clk) !nreset |=> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind usb_rx_top usb_rx_chk #(
    .DEPTH (FIFO_DEPTH)
) i_usb_rx_chk (
    .clk        (clk),
    .nreset     (nreset),
    .out_valid  (out_valid),
    .out_entry  (out_entry),
    .out_ready  (out_ready),
    .wr_en      (wr_en),
    .fifo_count (32'(i_usb_rx_fifo.count))
);

// File: tb_usb_rx.sv
`timescale 1ns/1ps

module tb_usb_rx;
    import usb_rx_pkg::*;

    localparam int FIFO_DEPTH = 8;
    localparam int IDLE_BITS  = 16;

    // Injected faults for send_packet.
    localparam int ERR_NONE    = 0;
    localparam int ERR_BAD_PID = 1;
    localparam int ERR_SE1     = 2;
    localparam int ERR_STUFF   = 3;
    localparam int ERR_SE0     = 4;

    logic        clk;
    logic        nreset;
    logic        dp_in;
    logic        dm_in;
    logic        out_valid;
    rx_entry_t   out_entry;
    logic        out_ready;
    logic [1:0]  reg_addr;
    logic [7:0]  reg_wdata;
    logic        reg_write;
    logic [7:0]  reg_rdata;

    integer      seed = 32'h97f8;
    int          errors = 0;
    int          checks = 0;
    logic        ready_random = 1'b0;
    logic        ready_level = 1'b1;
    line_state_t level;
    int          ones_run;
    logic [7:0]  payload [16];
    rx_entry_t   exp_q [$];

    usb_rx_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .IDLE_BITS  (IDLE_BITS)
    ) i_usb_rx_top (
        .clk       (clk),
        .nreset    (nreset),
        .dp_in     (dp_in),
        .dm_in     (dm_in),
        .out_valid (out_valid),
        .out_entry (out_entry),
        .out_ready (out_ready),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_write (reg_write),
        .reg_rdata (reg_rdata)
    );

    always begin
        clk = 1'b0;
        #20;
        clk = 1'b1;
        #20;
    end

    always @(posedge clk) begin
        #2;
        out_ready = ready_random ? (($random(seed) % 2) != 0) : ready_level;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, want);
            errors++;
        end
    endtask

    // ########################################################################
    // Reference model
    // ########################################################################

    function automatic void build_expected(input logic [7:0] pid, input int nbytes,
                                           input int kind, input bit held);
        int occ;
        occ = 0;
        if (kind == ERR_BAD_PID || pid[7:4] != ~pid[3:0]) begin
            return;
        end
        exp_q.push_back('{data: pid, tag: TAG_PID});
        occ = held ? occ + 1 : 0;
        for (int i = 0; i < nbytes; i++) begin
            if (occ >= FIFO_DEPTH - 1) begin
                exp_q.push_back('{data: 8'h00, tag: TAG_ABORT});
                return;
            end
            exp_q.push_back('{data: payload[i], tag: TAG_DATA});
            occ = held ? occ + 1 : 0;
        end
        if (kind == ERR_NONE) begin
            exp_q.push_back('{data: 8'h00, tag: TAG_EOP});
        end else begin
            exp_q.push_back('{data: 8'h00, tag: TAG_ABORT});
        end
    endfunction

    always @(posedge clk) begin
        if (nreset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Received an entry while none was expected: 0x%0h", out_entry);
                errors++;
            end else begin
                check_val("out_entry", 32'(out_entry), 32'(exp_q.pop_front()));
            end
        end
    end

    // ########################################################################
    // Line encoder
    // ########################################################################

    task automatic hold_line(input line_state_t st, input int bits);
        {dp_in, dm_in} = st;
        repeat (4 * bits) @(posedge clk);
        #2;
    endtask

    task automatic send_bit(input logic b, input bit stuffing);
        if (!b) begin
            level = (level == LINE_J) ? LINE_K : LINE_J;
            ones_run = 0;
        end else begin
            ones_run++;
        end
        hold_line(level, 1);
        if (stuffing && ones_run == 6) begin
            send_bit(1'b0, 1'b0);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            send_bit(b[i], 1'b1);
        end
    endtask

    task automatic send_packet(input logic [7:0] pid, input int nbytes, input int kind);
        level = LINE_J;
        ones_run = 0;
        hold_line(LINE_J, IDLE_BITS + 4);
        send_byte(SYNC_BYTE);
        send_byte(pid);
        for (int i = 0; i < nbytes; i++) begin
            send_byte(payload[i]);
        end
        case (kind)
            ERR_SE1: hold_line(LINE_SE1, 1);
            ERR_STUFF: begin
                for (int i = 0; i < 7; i++) begin
                    send_bit(1'b1, 1'b0);
                end
            end
            ERR_SE0: begin
                for (int i = 0; i < 3; i++) begin
                    send_bit(payload[0][i], 1'b1);
                end
            end
            default: ;
        endcase
        hold_line(LINE_SE0, 2);
        level = LINE_J;
        hold_line(LINE_J, 4);
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 4000) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d expected entries never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic read_reg(input logic [1:0] a, output logic [7:0] d);
        reg_addr = a;
        #10;
        d = reg_rdata;
        @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input logic [1:0] a, input logic [7:0] d);
        reg_addr  = a;
        reg_wdata = d;
        reg_write = 1'b1;
        @(posedge clk);
        #2;
        reg_write = 1'b0;
    endtask

    task automatic run_packet(input logic [7:0] pid, input int nbytes, input int kind);
        build_expected(pid, nbytes, kind, 1'b0);
        send_packet(pid, nbytes, kind);
        wait_drain();
    endtask

    // ########################################################################
    // Stimulus
    // ########################################################################

    initial begin
        logic [7:0] rd;
        logic [7:0] pid;
        logic [3:0] n;
        nreset    = 1'b0;
        dp_in     = 1'b1;
        dm_in     = 1'b0;
        out_ready = 1'b1;
        reg_addr  = 2'd0;
        reg_wdata = 8'd0;
        reg_write = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        nreset = 1'b1;

        check_val("out_valid", 32'(out_valid), 32'd0);
        read_reg(REG_CTRL, rd);
        check_val("reg_ctrl", 32'(rd), 32'h01);
        read_reg(REG_PKT_COUNT, rd);
        check_val("reg_pkt_count", 32'(rd), 32'h00);
        read_reg(REG_ERR_COUNT, rd);
        check_val("reg_err_count", 32'(rd), 32'h00);

        // Good packets with a random consumer.
        ready_random = 1'b1;
        for (int p = 0; p < 10; p++) begin
            n = 4'($random(seed));
            pid = {~n, n};
            for (int i = 0; i < 16; i++) begin
                payload[i] = 8'($random(seed));
            end
            run_packet(pid, $unsigned($random(seed)) % 7, ERR_NONE);
        end
        read_reg(REG_PKT_COUNT, rd);
        check_val("reg_pkt_count", 32'(rd), 32'd10);
        read_reg(REG_LAST_PID, rd);
        check_val("reg_last_pid", 32'(rd), 32'(pid));

        // Stuffed payloads and a stuffing fault.
        for (int i = 0; i < 16; i++) begin
            payload[i] = 8'hff;
        end
        run_packet(8'hc3, 3, ERR_NONE);
        payload[0] = 8'h3f;
        payload[1] = 8'h3f;
        run_packet(8'h4b, 2, ERR_NONE);
        run_packet(8'h4b, 1, ERR_STUFF);

        // Line errors.
        payload[0] = 8'h5a;
        run_packet(8'h11, 2, ERR_BAD_PID);
        run_packet(8'hd2, 1, ERR_SE1);
        run_packet(8'hd2, 1, ERR_SE0);
        read_reg(REG_ERR_COUNT, rd);
        check_val("reg_err_count", 32'(rd), 32'd4);
        write_reg(REG_ERR_COUNT, 8'h00);
        read_reg(REG_ERR_COUNT, rd);
        check_val("reg_err_count", 32'(rd), 32'd0);

        // Overflow with the consumer stalled.
        ready_random = 1'b0;
        ready_level  = 1'b0;
        for (int i = 0; i < 16; i++) begin
            payload[i] = 8'(i * 8'h11 + 8'h01);
        end
        build_expected(8'he1, 10, ERR_NONE, 1'b1);
        send_packet(8'he1, 10, ERR_NONE);
        check_val("out_valid", 32'(out_valid), 32'd1);
        ready_level = 1'b1;
        wait_drain();
        run_packet(8'he1, 4, ERR_NONE);

        // Receiver disabled, then enabled again.
        write_reg(REG_CTRL, 8'h00);
        read_reg(REG_PKT_COUNT, rd);
        check_val("reg_pkt_count", 32'(rd), 32'd13);
        send_packet(8'h69, 3, ERR_NONE);
        hold_line(LINE_J, 8);
        read_reg(REG_PKT_COUNT, rd);
        check_val("reg_pkt_count", 32'(rd), 32'd13);
        write_reg(REG_CTRL, 8'h01);
        run_packet(8'h69, 3, ERR_NONE);
        read_reg(REG_PKT_COUNT, rd);
        check_val("reg_pkt_count", 32'(rd), 32'd14);

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
usb_rx_pkg.sv
usb_line_sampler.sv
usb_nrzi_decoder.sv
usb_packet_receiver.sv
usb_rx_fifo.sv
usb_rx_regs.sv
usb_rx_top.sv
usb_rx_chk.sv
tb_usb_rx.sv

// File: run_tb.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_usb_rx
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_usb_rx)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1
